//--- sources.f
hw/fe_pkg.sv
hw/pc_gen.sv
hw/if_stage.sv
hw/id_stage.sv
hw/fetch_top.sv
verification/tb_clkgen.sv
verification/tb_inst_sram.sv
verification/fetch_assertions.sv
verification/tb_fetch.sv

//--- Bender.yml
package:
  name: rv32_fetch_front_end

sources:
  - hw/fe_pkg.sv
  - hw/pc_gen.sv
  - hw/if_stage.sv
  - hw/id_stage.sv
  - hw/fetch_top.sv
  - target: test
    files:
      - verification/tb_clkgen.sv
      - verification/tb_inst_sram.sv
      - verification/fetch_assertions.sv
      - verification/tb_fetch.sv

//--- verification/tb_fetch.sv
// testbench top with memory contents, expected pc model, execute stalls and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

  localparam int N_INST = 2000;   // accepted instructions per run
  localparam int CLK_NS = 4;

  logic                             clk;
  logic                             rst;
  logic                             ren;
  logic [fe_pkg::SRAM_ADDR_WD-1:0]  sram_addr;
  logic                             addr_ok;
  logic                             data_ok;
  logic [fe_pkg::SRAM_DATA_WD-1:0]  rdata;
  logic [fe_pkg::SRAM_ADDR_WD-1:0]  word_addr;
  logic [fe_pkg::SRAM_DATA_WD-1:0]  mem_word;
  logic                             es_allowin;
  logic                             es_valid;
  fe_pkg::ds_to_es_bus_t            es_bus;
  logic [fe_pkg::PC_WD-1:0]         exp_pc;
  int                               n_acc;
  integer                           seed;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
    abort_run($sformatf("ERROR %s expected %h actual %h", test, exp, act));
  endtask

  // planted control flow per 256 byte block, zero for a plain slot
  function automatic logic [20:0] planted_offset(input logic [31:0] pc);
    case (pc[7:0])
      8'h1c:   return 21'h00_0024;   // beq x0,x0 forward
      8'h64:   return 21'h00_0120;   // jal into the next block
      8'hc8:   return 21'h1f_ff80;   // beq x0,x0 back by 128
      default: return 21'h0;
    endcase
  endfunction

  function automatic logic [31:0] mem_slot(input logic [31:0] pc);
    fe_pkg::inst_fmt_u f;
    logic [20:0]       off;
    off = planted_offset(pc);
    if (off == 21'h0) begin
      // addi x1 with pc[11:0] as immediate, rs1 folded from the upper pc bits
      f = {pc[11:0], pc[16:12] ^ pc[21:17] ^ pc[26:22] ^ pc[31:27], 3'b000, 5'd1, 7'b001_0011};
    end else if (pc[7:0] == 8'h64) begin
      f.j = {off[20], off[10:1], off[11], off[19:12], 5'd0, fe_pkg::OPC_JAL};
    end else begin
      f.b = {off[12], off[10:5], 5'd0, 5'd0, fe_pkg::F3_BEQ, off[4:1], off[11],
             fe_pkg::OPC_BRANCH};
    end
    return f;
  endfunction

  function automatic logic [31:0] follow_pc(input logic [31:0] pc);
    logic [20:0] off;
    off = planted_offset(pc);
    return (off == 21'h0) ? pc + 32'd4 : pc + {{11{off[20]}}, off};
  endfunction

  assign mem_word = {mem_slot(word_addr + 32'd4), mem_slot(word_addr)};

  tb_clkgen clkgen0 (
    .o_clk (clk),
    .o_rst (rst)
  );

  tb_inst_sram mem0 (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_ren       (ren),
    .i_addr      (sram_addr),
    .i_word      (mem_word),
    .o_addr_ok   (addr_ok),
    .o_data_ok   (data_ok),
    .o_rdata     (rdata),
    .o_word_addr (word_addr)
  );

  fetch_top dut0 (
    .i_clk               (clk),
    .i_rst               (rst),
    .o_inst_sram_ren     (ren),
    .o_inst_sram_addr    (sram_addr),
    .i_inst_sram_addr_ok (addr_ok),
    .i_inst_sram_data_ok (data_ok),
    .i_inst_sram_rdata   (rdata),
    .i_es_allowin        (es_allowin),
    .o_ds_to_es_valid    (es_valid),
    .o_ds_to_es_bus      (es_bus)
  );

  // execute stalls about a third of the cycles
  initial begin
    seed       = 89;
    es_allowin = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      es_allowin = ($unsigned($random(seed)) % 3) != 0;
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      exp_pc <= fe_pkg::PC_RESETVAL;
      n_acc  <= 0;
    end else if (es_valid && es_allowin) begin
      exp_pc <= follow_pc(exp_pc);
      n_acc  <= n_acc + 1;
    end
  end

  a_reset_quiet: assert property (@(posedge clk) $past(rst) |-> !ren && !es_valid)
    else abort_run("sram request or execute valid active right after reset");

  a_pc_order: assert property (@(posedge clk) disable iff (rst)
      es_valid && es_allowin |-> es_bus.pc == exp_pc)
    else report_mismatch("pc_order", $sampled(exp_pc), $sampled(es_bus.pc));

  a_inst_word: assert property (@(posedge clk) disable iff (rst)
      es_valid |-> es_bus.inst == mem_slot(es_bus.pc))
    else report_mismatch("inst_word", mem_slot($sampled(es_bus.pc)), $sampled(es_bus.inst));

  a_es_hold: assert property (@(posedge clk) disable iff (rst)
      es_valid && !es_allowin |=> es_valid && $stable(es_bus))
    else abort_run("decode output dropped or changed while execute stalled");

  always @(posedge clk) begin
    if (dut0.u_fetch_asrt.fail_cnt != 0) begin
      abort_run("bound protocol assertion failed");
    end
  end

  initial begin
    #(N_INST * 8 * CLK_NS);
    abort_run("watchdog expired before all instructions were accepted");
  end

  initial begin
    wait (n_acc == N_INST);
    @(posedge clk);
    if (dut0.u_fetch_asrt.fail_cnt == 0) begin
      $display("test passed");
      $finish;
    end else begin
      abort_run("bound protocol assertion failed");
    end
  end

endmodule

`default_nettype wire

//--- verification/fetch_assertions.sv
// protocol assertions on the sram port, fetch to decode handshake and redirect pulse, with bind
`timescale 1ns/1ps
`default_nettype none

module fetch_assertions (
  input logic                             i_clk,
  input logic                             i_rst,
  input logic                             i_ren,
  input logic [fe_pkg::SRAM_ADDR_WD-1:0]  i_addr,
  input logic                             i_addr_ok,
  input logic                             i_data_ok,
  input logic                             i_fs_valid,
  input logic                             i_ds_allowin,
  input fe_pkg::fs_to_ds_bus_t            i_fs_bus,
  input fe_pkg::br_bus_t                  i_br_bus
);

  int unsigned fail_cnt = 0;
  logic        pend;   // accepted, response not back yet

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pend <= 1'b0;
    end else if (i_ren && i_addr_ok) begin
      pend <= 1'b1;
    end else if (i_data_ok) begin
      pend <= 1'b0;
    end
  end

  a_addr_align: assert property (@(posedge i_clk) disable iff (i_rst)
      i_ren |-> (i_addr[2:0] == 3'b000))
    else begin
      $error("sram request address is not 8-byte aligned");
      fail_cnt = fail_cnt + 1;
    end

  a_one_pending: assert property (@(posedge i_clk) disable iff (i_rst)
      pend |-> !i_ren)
    else begin
      $error("new sram request while one is outstanding");
      fail_cnt = fail_cnt + 1;
    end

  a_fs_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_fs_valid && !i_ds_allowin |=> i_fs_valid && $stable(i_fs_bus))
    else begin
      $error("fetch output dropped or changed while decode stalled");
      fail_cnt = fail_cnt + 1;
    end

  a_br_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
      i_br_bus.taken |=> !i_br_bus.taken)
    else begin
      $error("redirect held longer than one cycle");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind fetch_top fetch_assertions u_fetch_asrt (
  .i_clk        (i_clk),
  .i_rst        (i_rst),
  .i_ren        (o_inst_sram_ren),
  .i_addr       (o_inst_sram_addr),
  .i_addr_ok    (i_inst_sram_addr_ok),
  .i_data_ok    (i_inst_sram_data_ok),
  .i_fs_valid   (fs_to_ds_valid),
  .i_ds_allowin (ds_allowin),
  .i_fs_bus     (fs_to_ds_bus),
  .i_br_bus     (br_bus)
);

`default_nettype wire

//--- verification/tb_inst_sram.sv
// split request/response instruction memory model with random response delay
`timescale 1ns/1ps
`default_nettype none

module tb_inst_sram (
  input  logic                             i_clk,
  input  logic                             i_rst,
  input  logic                             i_ren,
  input  logic [fe_pkg::SRAM_ADDR_WD-1:0]  i_addr,
  input  logic [fe_pkg::SRAM_DATA_WD-1:0]  i_word,   // contents at o_word_addr
  output logic                             o_addr_ok,
  output logic                             o_data_ok,
  output logic [fe_pkg::SRAM_DATA_WD-1:0]  o_rdata,
  output logic [fe_pkg::SRAM_ADDR_WD-1:0]  o_word_addr
);

  integer                           seed;
  logic                             busy;       // one request being served
  logic                             take;
  logic [fe_pkg::SRAM_ADDR_WD-1:0]  addr_in;
  int unsigned                      wait_cyc;

  initial begin
    seed        = 89;
    busy        = 1'b0;
    take        = 1'b0;
    o_data_ok   = 1'b0;
    o_word_addr = '0;
    wait_cyc    = 0;
  end

  assign o_addr_ok = ~busy;
  assign o_rdata   = i_word;

  // sample at the edge, answer 1 ns later
  always @(posedge i_clk) begin
    take    = i_ren & o_addr_ok;
    addr_in = i_addr;
    #1;
    o_data_ok = 1'b0;
    if (i_rst) begin
      busy = 1'b0;
    end else begin
      if (take) begin
        busy        = 1'b1;
        o_word_addr = addr_in;
        wait_cyc    = 1 + ($unsigned($random(seed)) % 3);  // 1 to 3 cycles
      end
      if (busy) begin
        wait_cyc = wait_cyc - 1;
        if (wait_cyc == 0) begin
          busy      = 1'b0;
          o_data_ok = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_clkgen.sv
// testbench clock and synchronous reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;  // 4 ns period
  end

  // held over 4 rising edges, released just after the last one
  initial begin
    o_rst = 1'b1;
    repeat (4) @(posedge o_clk);
    #1;
    o_rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- hw/fetch_top.sv
// front end top connecting pc generator, fetch and decode to sram and execute
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic                             i_clk,
  input  logic                             i_rst,
  // inst sram
  output logic                             o_inst_sram_ren,
  output logic [fe_pkg::SRAM_ADDR_WD-1:0]  o_inst_sram_addr,
  input  logic                             i_inst_sram_addr_ok,
  input  logic                             i_inst_sram_data_ok,
  input  logic [fe_pkg::SRAM_DATA_WD-1:0]  i_inst_sram_rdata,
  // to execute
  input  logic                             i_es_allowin,
  output logic                             o_ds_to_es_valid,
  output fe_pkg::ds_to_es_bus_t            o_ds_to_es_bus
);

  logic                       load;
  logic [fe_pkg::PC_WD-1:0]   req_pc;
  fe_pkg::br_bus_t            br_bus;
  logic                       fs_to_ds_valid;
  fe_pkg::fs_to_ds_bus_t      fs_to_ds_bus;
  logic                       ds_allowin;

  pc_gen u_pc_gen (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_load           (load),
    .i_br_bus         (br_bus),
    .o_pc             (req_pc),
    .o_inst_sram_addr (o_inst_sram_addr),
    .o_inst_sram_ren  (o_inst_sram_ren)
  );

  if_stage u_if_stage (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_addr_ok        (i_inst_sram_addr_ok),
    .i_data_ok        (i_inst_sram_data_ok),
    .i_rdata          (i_inst_sram_rdata),
    .i_req_pc         (req_pc),
    .i_br_bus         (br_bus),
    .i_ds_allowin     (ds_allowin),
    .o_load           (load),
    .o_fs_to_ds_valid (fs_to_ds_valid),
    .o_fs_to_ds_bus   (fs_to_ds_bus)
  );

  id_stage u_id_stage (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_fs_to_ds_valid (fs_to_ds_valid),
    .i_fs_to_ds_bus   (fs_to_ds_bus),
    .i_es_allowin     (i_es_allowin),
    .o_ds_allowin     (ds_allowin),
    .o_br_bus         (br_bus),   // back to pc_gen and fetch
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_to_es_bus   (o_ds_to_es_bus)
  );

endmodule

`default_nettype wire

//--- hw/id_stage.sv
// decode stage with jal and beq x0,x0 target computation and branch bus
`timescale 1ns/1ps
`default_nettype none

module id_stage (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_fs_to_ds_valid,
  input  fe_pkg::fs_to_ds_bus_t   i_fs_to_ds_bus,
  input  logic                    i_es_allowin,
  output logic                    o_ds_allowin,
  output fe_pkg::br_bus_t         o_br_bus,
  output logic                    o_ds_to_es_valid,
  output fe_pkg::ds_to_es_bus_t   o_ds_to_es_bus
);

  logic                       ds_valid_q;
  fe_pkg::fs_to_ds_bus_t      ds_bus_q;
  fe_pkg::inst_fmt_u          fmt;
  logic                       is_jal;
  logic                       is_beq_x0;
  logic                       ds_leave;
  logic                       br_taken;
  logic [fe_pkg::PC_WD-1:0]   j_imm;
  logic [fe_pkg::PC_WD-1:0]   b_imm;
  logic [fe_pkg::PC_WD-1:0]   br_offset;
  logic [fe_pkg::PC_WD-1:0]   br_target;

  // decode always finishes in one cycle
  assign o_ds_allowin = ~ds_valid_q | i_es_allowin;
  assign ds_leave     = ds_valid_q & i_es_allowin;

  // incoming word on the redirect cycle is wrong path
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid_q <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid_q <= i_fs_to_ds_valid & ~br_taken;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_ds_allowin && i_fs_to_ds_valid) begin
      ds_bus_q <= i_fs_to_ds_bus;
    end
  end

  assign fmt = ds_bus_q.inst;

  assign is_jal = (fmt.j.opcode == fe_pkg::OPC_JAL);

  // only the always taken form, no register read needed
  assign is_beq_x0 = (fmt.b.opcode == fe_pkg::OPC_BRANCH) &&
                     (fmt.b.funct3 == fe_pkg::F3_BEQ) &&
                     (fmt.b.rs1 == 5'd0) &&
                     (fmt.b.rs2 == 5'd0);

  // sign extended, bit 0 always zero
  assign j_imm = {{11{fmt.j.imm_20}},
                  fmt.j.imm_20,
                  fmt.j.imm_19_12,
                  fmt.j.imm_11,
                  fmt.j.imm_10_1,
                  1'b0};

  assign b_imm = {{19{fmt.b.imm_12}},
                  fmt.b.imm_12,
                  fmt.b.imm_11,
                  fmt.b.imm_10_5,
                  fmt.b.imm_4_1,
                  1'b0};

  assign br_offset = is_jal ? j_imm : b_imm;
  assign br_target = ds_bus_q.pc + br_offset;

  // pulse as the branch moves on to execute
  assign br_taken = ds_leave & (is_jal | is_beq_x0);

  assign o_br_bus.taken  = br_taken;
  assign o_br_bus.target = br_target;

  assign o_ds_to_es_valid    = ds_valid_q;
  assign o_ds_to_es_bus.inst = ds_bus_q.inst;
  assign o_ds_to_es_bus.pc   = ds_bus_q.pc;

endmodule

`default_nettype wire

//--- hw/if_stage.sv
// fetch stage with request tracking, response buffer, half select and redirect cancel
`timescale 1ns/1ps
`default_nettype none

module if_stage (
  input  logic                             i_clk,
  input  logic                             i_rst,
  input  logic                             i_addr_ok,
  input  logic                             i_data_ok,
  input  logic [fe_pkg::SRAM_DATA_WD-1:0]  i_rdata,
  input  logic [fe_pkg::PC_WD-1:0]         i_req_pc,
  input  fe_pkg::br_bus_t                  i_br_bus,
  input  logic                             i_ds_allowin,
  output logic                             o_load,
  output logic                             o_fs_to_ds_valid,
  output fe_pkg::fs_to_ds_bus_t            o_fs_to_ds_bus
);

  logic                          run_q;       // low during and just after reset
  logic                          inflight_q;  // one request outstanding
  logic                          cancel_q;    // outstanding request is wrong path
  logic [fe_pkg::PC_WD-1:0]      req_pc_q;
  logic                          fs_valid_q;
  fe_pkg::fs_to_ds_bus_t         fs_bus_q;
  logic                          br_taken;
  logic                          fs_leave;
  logic                          fs_room;
  logic                          rsp_keep;
  logic [fe_pkg::INST_WD-1:0]    rsp_inst;

  assign br_taken = i_br_bus.taken;
  assign fs_leave = fs_valid_q & i_ds_allowin;
  assign fs_room  = ~fs_valid_q | fs_leave;

  // new request only with nothing in flight and the buffer free or draining
  assign o_load = run_q & ~inflight_q & fs_room & i_addr_ok;

  // drop responses of cancelled requests and anything landing on a redirect
  assign rsp_keep = i_data_ok & inflight_q & ~cancel_q & ~br_taken;

  // pc[2] selects the upper half of the 64-bit word
  assign rsp_inst = req_pc_q[2] ? i_rdata[fe_pkg::SRAM_DATA_WD-1:fe_pkg::INST_WD]
                                : i_rdata[fe_pkg::INST_WD-1:0];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      inflight_q <= 1'b0;
      cancel_q   <= 1'b0;
    end else if (o_load) begin
      inflight_q <= 1'b1;
      cancel_q   <= br_taken;   // issued from the old pc
    end else if (i_data_ok) begin
      inflight_q <= 1'b0;
      cancel_q   <= 1'b0;
    end else if (br_taken) begin
      cancel_q   <= inflight_q;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_load) begin
      req_pc_q <= i_req_pc;
    end
  end

  // buffer empties on a redirect, its word is the sequential successor
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      fs_valid_q <= 1'b0;
    end else if (br_taken) begin
      fs_valid_q <= 1'b0;
    end else if (rsp_keep) begin
      fs_valid_q <= 1'b1;
    end else if (fs_leave) begin
      fs_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (rsp_keep) begin
      fs_bus_q.inst <= rsp_inst;
      fs_bus_q.pc   <= req_pc_q;
    end
  end

  assign o_fs_to_ds_valid = fs_valid_q;
  assign o_fs_to_ds_bus   = fs_bus_q;

endmodule

`default_nettype wire

//--- hw/pc_gen.sv
// pre-fetch pc register, next pc selection and instruction sram address
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
  input  logic                             i_clk,
  input  logic                             i_rst,
  input  logic                             i_load,    // request accepted this cycle
  input  fe_pkg::br_bus_t                  i_br_bus,
  output logic [fe_pkg::PC_WD-1:0]         o_pc,
  output logic [fe_pkg::SRAM_ADDR_WD-1:0]  o_inst_sram_addr,
  output logic                             o_inst_sram_ren
);

  logic [fe_pkg::PC_WD-1:0] pc_q;
  logic [fe_pkg::PC_WD-1:0] pc_seq;
  logic [fe_pkg::PC_WD-1:0] pc_next;

  assign pc_seq = pc_q + {{(fe_pkg::PC_WD-3){1'b0}}, 3'd4};

  // redirect wins over the sequential step
  // a request accepted in the same cycle is wrong path and gets cancelled in fetch
  always_comb begin
    if (i_br_bus.taken) begin
      pc_next = i_br_bus.target;
    end else if (i_load) begin
      pc_next = pc_seq;
    end else begin
      pc_next = pc_q;
    end
  end

  // pc_q holds the next fetch address, so a redirect seen
  // without a load simply parks the target here until the next request
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q <= fe_pkg::PC_RESETVAL;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign o_pc = pc_q;

  // memory returns a 64-bit word, fetch picks the half with pc[2]
  assign o_inst_sram_addr = {pc_q[fe_pkg::SRAM_ADDR_WD-1:3], 3'b000};

  // ren only goes up when fetch has room and the memory shows addr_ok,
  // so every ren is an accepted request
  assign o_inst_sram_ren = i_load;

endmodule

`default_nettype wire

//--- hw/fe_pkg.sv
// front end widths, reset pc, opcodes, stage bus structs and instruction format union
`default_nettype none

package fe_pkg;

  localparam int unsigned INST_WD      = 32;
  localparam int unsigned PC_WD        = 32;
  localparam int unsigned SRAM_ADDR_WD = 32;
  localparam int unsigned SRAM_DATA_WD = 64;

  localparam logic [PC_WD-1:0] PC_RESETVAL = 32'h8000_0000;  // first fetch after reset

  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [2:0] F3_BEQ     = 3'b000;

  // decode to fetch redirect
  typedef struct packed {
    logic             taken;   // one cycle pulse
    logic [PC_WD-1:0] target;
  } br_bus_t;

  typedef struct packed {
    logic [INST_WD-1:0] inst;
    logic [PC_WD-1:0]   pc;
  } fs_to_ds_bus_t;

  typedef struct packed {
    logic [INST_WD-1:0] inst;
    logic [PC_WD-1:0]   pc;
  } ds_to_es_bus_t;

  // jal layout
  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // conditional branch layout
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef union packed {
    j_fmt_t j;
    b_fmt_t b;
  } inst_fmt_u;

endpackage

`default_nettype wire
